//--- hdl/cq_rx_consts.svh
// completer request layout for a 256-bit dword-aligned CQ port
// field positions assume the 4-dword descriptor sits in the lower half of the start beat
`ifndef CQ_RX_CONSTS_SVH
`define CQ_RX_CONSTS_SVH

//////////////////////////////
// widths
//////////////////////////////
`define CQ_DATA_W        256    // one beat, one fifo word
`define DW_W             32
`define BEAT_DW          8      // dwords per beat
`define SHORT_WR_MAX_DW  4      // payload room left in the header beat

//////////////////////////////
// descriptor field positions
//////////////////////////////
`define CQ_ADDR_LSB      2      // dword address, byte offset dropped
`define CQ_LEN_LSB       64     // dword count
`define CQ_TYPE_LSB      75     // request code
`define CQ_RID_LSB       80
`define CQ_TAG_LSB       96
`define CQ_TC_LSB        121
`define CQ_ATTR_LSB      124

// request codes
`define REQ_MEM_RD       0
`define REQ_MEM_WR       1

// 100 ms at 250 MHz
`define RATE_WINDOW_DEFAULT 25000000

`endif

//--- hdl/cq_rx_pkg.sv
// shared types of the completer request receive path
`default_nettype none

`include "cq_rx_consts.svh"

package cq_rx_pkg;

   // beat and fifo word share one width
   typedef logic [`CQ_DATA_W-1:0]   cq_data_t;
   typedef logic [`CQ_DATA_W/2-1:0] half_beat_t;   // carried upper half

   typedef logic [10:0] dw_len_t;    // dword count of a request
   typedef logic [10:0] ep_addr_t;   // dword address into the endpoint
   typedef logic [3:0]  req_type_t;
   typedef logic [2:0]  tc_t;
   typedef logic [2:0]  attr_t;
   typedef logic [15:0] rid_t;
   typedef logic [7:0]  tag_t;
   typedef logic [7:0]  be_t;        // first and last dword byte enables
   typedef logic [31:0] rate_t;      // fifo words per window

   // engine states
   typedef enum logic [1:0] {
      CQ_IDLE     = 2'd0,   // waiting for a start beat, or draining an ignored packet
      CQ_WR_BODY  = 2'd1,   // continuation beats of a long write
      CQ_WR_FLUSH = 2'd2,   // one cycle, carry may still hold payload
      CQ_RD_WAIT  = 2'd3    // completion pending on the tx side
   } cq_rx_state_e;

endpackage

`default_nettype wire

//--- hdl/cq_rx_fsm.sv
// one FSM for the CQ port; only start beats are decoded, other beats are framing only
// long writes leave the body on wr_last or tlast, whichever comes first
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module cq_rx_fsm (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cq_tvalid_i,
   input  logic                  cq_tlast_i,
   input  cq_rx_pkg::req_type_t  cq_type_i,
   input  cq_rx_pkg::dw_len_t    cq_len_i,
   input  logic                  compl_done_i,
   input  logic                  wr_last_i,
   output logic                  cq_tready_o,
   output logic                  req_compl_o,
   output logic                  rd_capture_o,
   output logic                  wr_short_o,
   output logic                  wr_start_o,
   output logic                  wr_beat_o,
   output logic                  wr_flush_o
);

   cq_rx_pkg::cq_rx_state_e state_q;
   cq_rx_pkg::cq_rx_state_e state_d;
   logic in_pkt_q;    // inside a packet, next beat is no start beat
   logic accept;
   logic sop;         // accepted start beat in idle
   logic is_rd;
   logic is_wr;

   //////////////////////////////
   // framing
   //////////////////////////////
   assign accept = cq_tvalid_i & cq_tready_o;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
      end else if (accept) begin
         in_pkt_q <= ~cq_tlast_i;   // tlast closes, anything else keeps it open
      end
   end

   //////////////////////////////
   // decode of start beats
   //////////////////////////////
   assign sop   = accept & ~in_pkt_q & (state_q == cq_rx_pkg::CQ_IDLE);
   assign is_rd = (cq_type_i == cq_rx_pkg::req_type_t'(`REQ_MEM_RD));
   assign is_wr = (cq_type_i == cq_rx_pkg::req_type_t'(`REQ_MEM_WR));

   // one-dword reads only, other lengths just drain
   assign rd_capture_o = sop & is_rd & (cq_len_i == cq_rx_pkg::dw_len_t'(1));
   assign wr_short_o   = sop & is_wr & (cq_len_i != '0) &
                         (cq_len_i <= cq_rx_pkg::dw_len_t'(`SHORT_WR_MAX_DW));
   // a long header with tlast is malformed, left to drain
   assign wr_start_o   = sop & is_wr & ~cq_tlast_i &
                         (cq_len_i > cq_rx_pkg::dw_len_t'(`SHORT_WR_MAX_DW));
   assign wr_beat_o    = accept & (state_q == cq_rx_pkg::CQ_WR_BODY);
   assign wr_flush_o   = (state_q == cq_rx_pkg::CQ_WR_FLUSH);

   // back-pressure only while flushing or waiting on the completion
   assign cq_tready_o = (state_q == cq_rx_pkg::CQ_IDLE) | (state_q == cq_rx_pkg::CQ_WR_BODY);
   assign req_compl_o = (state_q == cq_rx_pkg::CQ_RD_WAIT);

   //////////////////////////////
   // sequencing
   //////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         cq_rx_pkg::CQ_IDLE: begin
            if (rd_capture_o) begin
               state_d = cq_rx_pkg::CQ_RD_WAIT;
            end else if (wr_start_o) begin
               state_d = cq_rx_pkg::CQ_WR_BODY;
            end
         end
         cq_rx_pkg::CQ_WR_BODY: begin
            if (accept && (wr_last_i || cq_tlast_i)) begin
               state_d = cq_rx_pkg::CQ_WR_FLUSH;
            end
         end
         cq_rx_pkg::CQ_WR_FLUSH: state_d = cq_rx_pkg::CQ_IDLE;   // always one cycle
         cq_rx_pkg::CQ_RD_WAIT: begin
            if (compl_done_i) begin
               state_d = cq_rx_pkg::CQ_IDLE;
            end
         end
         default: state_d = cq_rx_pkg::CQ_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= cq_rx_pkg::CQ_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

`default_nettype wire

//--- hdl/wr_dw_repacker.sv
// payload dword i lands in slot i mod 8 of fifo word i div 8, unused slots zero
// fifo_wr_en_o has no back-pressure, the fifo must take every word
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module wr_dw_repacker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  cq_rx_pkg::cq_data_t  cq_tdata_i,
   input  cq_rx_pkg::dw_len_t   cq_len_i,
   input  logic                 wr_short_i,
   input  logic                 wr_start_i,
   input  logic                 wr_beat_i,
   input  logic                 wr_flush_i,
   output logic                 wr_last_o,
   output cq_rx_pkg::cq_data_t  fifo_wr_data_o,
   output logic                 fifo_wr_en_o
);

   localparam int HALF_W = `CQ_DATA_W / 2;
   localparam cq_rx_pkg::dw_len_t BEAT_LEN = cq_rx_pkg::dw_len_t'(`BEAT_DW);
   // carry 4 + one beat of 8 still closes the payload
   localparam cq_rx_pkg::dw_len_t LAST_LEN =
      cq_rx_pkg::dw_len_t'(`BEAT_DW + `SHORT_WR_MAX_DW);

   cq_rx_pkg::half_beat_t carry_q;   // upper half of the previous beat
   cq_rx_pkg::dw_len_t    rem_q;     // dwords still due to the fifo
   logic                  flush_pend_q;

   // zero every slot at or above n
   function automatic cq_rx_pkg::cq_data_t keep_dw(input cq_rx_pkg::cq_data_t word,
                                                   input cq_rx_pkg::dw_len_t n);
      cq_rx_pkg::cq_data_t res;
      res = '0;
      for (int i = 0; i < `BEAT_DW; i++) begin
         if (i < int'(n)) begin
            res[i*`DW_W +: `DW_W] = word[i*`DW_W +: `DW_W];
         end
      end
      return res;
   endfunction

   assign wr_last_o = (rem_q <= LAST_LEN);

   //////////////////////////////
   // control
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rem_q        <= '0;
         flush_pend_q <= 1'b0;
         fifo_wr_en_o <= 1'b0;
      end else begin
         fifo_wr_en_o <= wr_short_i | wr_beat_i | (wr_flush_i & flush_pend_q);
         if (wr_start_i) begin
            rem_q        <= cq_len_i;   // header dwords 0..3 go to the carry
            flush_pend_q <= 1'b0;
         end else if (wr_beat_i) begin
            if (rem_q > BEAT_LEN) begin
               rem_q <= rem_q - BEAT_LEN;
            end else begin
               rem_q <= '0;
            end
            flush_pend_q <= wr_last_o & (rem_q > BEAT_LEN);   // last beat overflowed
         end else if (wr_flush_i) begin
            rem_q        <= '0;
            flush_pend_q <= 1'b0;
         end
      end
   end

   //////////////////////////////
   // word assembly
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_short_i) begin
         fifo_wr_data_o <= keep_dw({{HALF_W{1'b0}}, cq_tdata_i[`CQ_DATA_W-1:HALF_W]}, cq_len_i);
      end else if (wr_beat_i) begin
         fifo_wr_data_o <= keep_dw({cq_tdata_i[HALF_W-1:0], carry_q}, rem_q);   // carry low
      end else if (wr_flush_i) begin
         fifo_wr_data_o <= keep_dw({{HALF_W{1'b0}}, carry_q}, rem_q);   // 1..4 left
      end
      if (wr_start_i || wr_beat_i) begin
         carry_q <= cq_tdata_i[`CQ_DATA_W-1:HALF_W];
      end
   end

endmodule

`default_nettype wire

//--- hdl/rd_req_capture.sv
// holds the last one-dword read for the tx side until the next read replaces it
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module rd_req_capture (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rd_capture_i,
   input  cq_rx_pkg::cq_data_t  cq_tdata_i,
   input  cq_rx_pkg::be_t       cq_be_i,
   output cq_rx_pkg::tc_t       req_tc_o,
   output cq_rx_pkg::attr_t     req_attr_o,
   output cq_rx_pkg::dw_len_t   req_len_o,
   output cq_rx_pkg::rid_t      req_rid_o,
   output cq_rx_pkg::tag_t      req_tag_o,
   output cq_rx_pkg::be_t       req_be_o,
   output cq_rx_pkg::ep_addr_t  req_addr_o
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_tc_o   <= '0;
         req_attr_o <= '0;
         req_len_o  <= '0;
         req_rid_o  <= '0;
         req_tag_o  <= '0;
         req_be_o   <= '0;
         req_addr_o <= '0;
      end else if (rd_capture_i) begin
         // descriptor upper dwords
         req_tc_o   <= cq_tdata_i[`CQ_TC_LSB +: $bits(cq_rx_pkg::tc_t)];
         req_attr_o <= cq_tdata_i[`CQ_ATTR_LSB +: $bits(cq_rx_pkg::attr_t)];
         req_len_o  <= cq_tdata_i[`CQ_LEN_LSB +: $bits(cq_rx_pkg::dw_len_t)];
         req_rid_o  <= cq_tdata_i[`CQ_RID_LSB +: $bits(cq_rx_pkg::rid_t)];
         req_tag_o  <= cq_tdata_i[`CQ_TAG_LSB +: $bits(cq_rx_pkg::tag_t)];
         req_be_o   <= cq_be_i;   // from the sideband
         // low address bits only, endpoint space is small
         req_addr_o <= cq_tdata_i[`CQ_ADDR_LSB +: $bits(cq_rx_pkg::ep_addr_t)];
      end
   end

endmodule

`default_nettype wire

//--- hdl/rx_rate_meter.sv
// counts fifo words per window of WINDOW_CYCLES clocks, restarted by rate_clear_i
// a word in the cycle of the rate_valid_o pulse counts toward the next window
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module rx_rate_meter #(
   parameter int unsigned WINDOW_CYCLES = `RATE_WINDOW_DEFAULT
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rate_clear_i,
   input  logic              fifo_wr_en_i,
   output cq_rx_pkg::rate_t  rate_count_o,
   output logic              rate_valid_o
);

   localparam int TIMER_W = $clog2(WINDOW_CYCLES + 1);
   localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(WINDOW_CYCLES - 1);

   logic [TIMER_W-1:0] timer_q;   // position inside the window
   cq_rx_pkg::rate_t   words_q;   // words so far in this window
   logic               win_end;

   assign win_end = (timer_q == TIMER_LAST);

   always_ff @(posedge clk) begin
      if (!rst_n || rate_clear_i) begin
         timer_q      <= '0;
         words_q      <= '0;
         rate_count_o <= '0;
         rate_valid_o <= 1'b0;
      end else begin
         rate_valid_o <= win_end;   // one pulse per window
         if (win_end) begin
            timer_q      <= '0;
            words_q      <= '0;
            // include a word on the last cycle of the window
            rate_count_o <= words_q + cq_rx_pkg::rate_t'(fifo_wr_en_i);
         end else begin
            timer_q <= timer_q + 1'b1;
            if (fifo_wr_en_i) begin
               words_q <= words_q + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/cq_rx_engine.sv
// completer request receive engine; writes of any length go to the fifo
// one-dword reads wait for compl_done_i, other requests are consumed and dropped
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module cq_rx_engine #(
   parameter int unsigned WINDOW_CYCLES = `RATE_WINDOW_DEFAULT
) (
   input  logic                 clk,
   input  logic                 rst_n,
   // completer request port
   input  cq_rx_pkg::cq_data_t  cq_tdata_i,
   input  logic                 cq_tvalid_i,
   input  logic                 cq_tlast_i,
   input  cq_rx_pkg::be_t       cq_be_i,
   output logic                 cq_tready_o,
   // read completion handshake
   output logic                 req_compl_o,
   input  logic                 compl_done_i,
   output cq_rx_pkg::tc_t       req_tc_o,
   output cq_rx_pkg::attr_t     req_attr_o,
   output cq_rx_pkg::dw_len_t   req_len_o,
   output cq_rx_pkg::rid_t      req_rid_o,
   output cq_rx_pkg::tag_t      req_tag_o,
   output cq_rx_pkg::be_t       req_be_o,
   output cq_rx_pkg::ep_addr_t  req_addr_o,
   // receive fifo
   output cq_rx_pkg::cq_data_t  fifo_wr_data_o,
   output logic                 fifo_wr_en_o,
   // throughput
   input  logic                 rate_clear_i,
   output cq_rx_pkg::rate_t     rate_count_o,
   output logic                 rate_valid_o
);

   cq_rx_pkg::req_type_t cq_type;
   cq_rx_pkg::dw_len_t   cq_len;
   logic rd_capture;
   logic wr_short;
   logic wr_start;
   logic wr_beat;
   logic wr_flush;
   logic wr_last;

   // descriptor fields, meaningful on start beats only
   assign cq_type = cq_tdata_i[`CQ_TYPE_LSB +: $bits(cq_rx_pkg::req_type_t)];
   assign cq_len  = cq_tdata_i[`CQ_LEN_LSB +: $bits(cq_rx_pkg::dw_len_t)];

   cq_rx_fsm u_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .cq_tvalid_i  (cq_tvalid_i),
      .cq_tlast_i   (cq_tlast_i),
      .cq_type_i    (cq_type),
      .cq_len_i     (cq_len),
      .compl_done_i (compl_done_i),
      .wr_last_i    (wr_last),
      .cq_tready_o  (cq_tready_o),
      .req_compl_o  (req_compl_o),
      .rd_capture_o (rd_capture),
      .wr_short_o   (wr_short),
      .wr_start_o   (wr_start),
      .wr_beat_o    (wr_beat),
      .wr_flush_o   (wr_flush)
   );

   wr_dw_repacker u_repack (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_tdata_i     (cq_tdata_i),
      .cq_len_i       (cq_len),
      .wr_short_i     (wr_short),
      .wr_start_i     (wr_start),
      .wr_beat_i      (wr_beat),
      .wr_flush_i     (wr_flush),
      .wr_last_o      (wr_last),
      .fifo_wr_data_o (fifo_wr_data_o),
      .fifo_wr_en_o   (fifo_wr_en_o)
   );

   rd_req_capture u_capture (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_capture_i (rd_capture),
      .cq_tdata_i   (cq_tdata_i),
      .cq_be_i      (cq_be_i),
      .req_tc_o     (req_tc_o),
      .req_attr_o   (req_attr_o),
      .req_len_o    (req_len_o),
      .req_rid_o    (req_rid_o),
      .req_tag_o    (req_tag_o),
      .req_be_o     (req_be_o),
      .req_addr_o   (req_addr_o)
   );

   rx_rate_meter #(
      .WINDOW_CYCLES (WINDOW_CYCLES)
   ) u_rate (
      .clk          (clk),
      .rst_n        (rst_n),
      .rate_clear_i (rate_clear_i),
      .fifo_wr_en_i (fifo_wr_en_o),   // counts words, not beats
      .rate_count_o (rate_count_o),
      .rate_valid_o (rate_valid_o)
   );

endmodule

`default_nettype wire

//--- test/cq_rx_engine_sva.sv
// port-level checks, bound into every cq_rx_engine
// the fail counters are read back by the testbench at the end of the run
`timescale 1ns/1ps
`default_nettype none

module cq_rx_engine_sva (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  cq_tready_i,
   input  logic  req_compl_i,
   input  logic  fifo_wr_en_i,
   input  logic  rate_valid_i
);

   int fails_compl  = 0;
   int fails_rate   = 0;
   int fails_fifo   = 0;
   int fails_reset  = 0;
   int assert_fails;

   assign assert_fails = fails_compl + fails_rate + fails_fifo + fails_reset;

   //////////////////////////////
   // handshake rules
   //////////////////////////////
   // pending completion stalls the port
   a_compl_stalls: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i |-> !cq_tready_i)
      else begin
         fails_compl++;
         $error("req_compl_o high while cq_tready_o is high");
      end

   a_rate_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      rate_valid_i |=> !rate_valid_i)   // one pulse per window
      else begin
         fails_rate++;
         $error("rate_valid_o high for two cycles in a row");
      end

   a_no_word_in_read: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_i |-> !fifo_wr_en_i)
      else begin
         fails_fifo++;
         $error("fifo_wr_en_o during a pending completion");
      end

   // idle state right out of reset
   a_ready_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> cq_tready_i)
      else begin
         fails_reset++;
         $error("cq_tready_o low in the first cycle after reset");
      end

endmodule

bind cq_rx_engine cq_rx_engine_sva u_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .cq_tready_i  (cq_tready_o),
   .req_compl_i  (req_compl_o),
   .fifo_wr_en_i (fifo_wr_en_o),
   .rate_valid_i (rate_valid_o)
);

`default_nettype wire

//--- test/tb_cq_rx_engine.sv
// directed tests for cq_rx_engine with WINDOW_CYCLES cut to 400
// the fifo is an always-ready queue and the source keeps valid high across a packet
`timescale 1ns/1ps
`default_nettype none

`include "cq_rx_consts.svh"

module tb_cq_rx_engine;

   localparam int WAIT_LIMIT = 1000;   // cycles per wait loop
   localparam int WINDOW     = 400;

   logic                 clk;
   logic                 rst_n;
   cq_rx_pkg::cq_data_t  cq_tdata;
   logic                 cq_tvalid;
   logic                 cq_tlast;
   cq_rx_pkg::be_t       cq_be;
   logic                 cq_tready;
   logic                 req_compl;
   logic                 compl_done;
   cq_rx_pkg::tc_t       req_tc;
   cq_rx_pkg::attr_t     req_attr;
   cq_rx_pkg::dw_len_t   req_len;
   cq_rx_pkg::rid_t      req_rid;
   cq_rx_pkg::tag_t      req_tag;
   cq_rx_pkg::be_t       req_be;
   cq_rx_pkg::ep_addr_t  req_addr;
   cq_rx_pkg::cq_data_t  fifo_wr_data;
   logic                 fifo_wr_en;
   logic                 rate_clear;
   cq_rx_pkg::rate_t     rate_count;
   logic                 rate_valid;

   int errors;
   int checks;
   int tests;
   int errors_at_start;
   int compl_cycles;                   // cycles seen with req_compl_o high
   logic [31:0] rnd_state;
   logic [31:0] pay [32];              // payload of the current write
   cq_rx_pkg::cq_data_t fifo_q[$];     // words seen on the fifo port
   cq_rx_pkg::cq_data_t exp_q[$];      // words from the slot rule

   cq_rx_engine #(
      .WINDOW_CYCLES (WINDOW)
   ) u_cq_rx_engine (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_tdata_i     (cq_tdata),
      .cq_tvalid_i    (cq_tvalid),
      .cq_tlast_i     (cq_tlast),
      .cq_be_i        (cq_be),
      .cq_tready_o    (cq_tready),
      .req_compl_o    (req_compl),
      .compl_done_i   (compl_done),
      .req_tc_o       (req_tc),
      .req_attr_o     (req_attr),
      .req_len_o      (req_len),
      .req_rid_o      (req_rid),
      .req_tag_o      (req_tag),
      .req_be_o       (req_be),
      .req_addr_o     (req_addr),
      .fifo_wr_data_o (fifo_wr_data),
      .fifo_wr_en_o   (fifo_wr_en),
      .rate_clear_i   (rate_clear),
      .rate_count_o   (rate_count),
      .rate_valid_o   (rate_valid)
   );

   always #20 clk = ~clk;   // 40 ns period

   // fifo and completion monitor sampling on the falling edge
   always @(negedge clk) begin
      if (rst_n && fifo_wr_en) begin
         fifo_q.push_back(fifo_wr_data);
      end
      if (rst_n && req_compl) begin
         compl_cycles++;
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////
   function automatic logic [31:0] next_rand();
      rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
      return rnd_state;
   endfunction

   // descriptor in dwords 0..3 with the upper half left to the caller
   function automatic cq_rx_pkg::cq_data_t make_header(input cq_rx_pkg::req_type_t typ,
         input cq_rx_pkg::dw_len_t len, input cq_rx_pkg::ep_addr_t addr,
         input cq_rx_pkg::rid_t rid, input cq_rx_pkg::tag_t tag,
         input cq_rx_pkg::tc_t tc, input cq_rx_pkg::attr_t attr);
      cq_rx_pkg::cq_data_t h;
      h = '0;
      h[`CQ_ADDR_LSB +: 11] = addr;   // dword-aligned byte address
      h[`CQ_LEN_LSB +: 11]  = len;
      h[`CQ_TYPE_LSB +: 4]  = typ;
      h[`CQ_RID_LSB +: 16]  = rid;
      h[`CQ_TAG_LSB +: 8]   = tag;
      h[`CQ_TC_LSB +: 3]    = tc;
      h[`CQ_ATTR_LSB +: 3]  = attr;
      return h;
   endfunction

   task automatic check_eq(input logic [255:0] got, input logic [255:0] expected,
                           input string what);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("[ERROR] %0d ns: %s: got %0h, expected %0h", $time, what, got, expected);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s done, %0d errors", tests, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   // runs from a falling edge to the falling edge after acceptance
   task automatic send_beat(input cq_rx_pkg::cq_data_t data, input logic last);
      int n;
      n = 0;
      cq_tdata  = data;
      cq_tvalid = 1'b1;
      cq_tlast  = last;
      while (!cq_tready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!cq_tready) begin
         errors++;
         $display("timeout: cq_tready_o stayed low for %0d cycles", n);
      end
      @(negedge clk);   // taken on the rising edge just passed
   endtask

   // write of len dwords with garbage past the payload end and its expected words queued
   task automatic send_write(input int len);
      cq_rx_pkg::cq_data_t beat;
      cq_rx_pkg::cq_data_t word;
      logic [31:0] r;
      int nbeats;
      int idx;
      for (int i = 0; i < len; i++) begin
         pay[i] = next_rand();
      end
      r = next_rand();
      beat = make_header(cq_rx_pkg::req_type_t'(`REQ_MEM_WR), cq_rx_pkg::dw_len_t'(len),
                         r[10:0], r[31:16], r[23:16], r[2:0], r[6:4]);
      for (int j = 0; j < 4; j++) begin
         beat[(4+j)*32 +: 32] = (j < len) ? pay[j] : next_rand();   // payload 0..3
      end
      nbeats = (len <= 4) ? 0 : (len - 4 + 7) / 8;
      send_beat(beat, nbeats == 0);
      for (int k = 0; k < nbeats; k++) begin
         for (int j = 0; j < 8; j++) begin
            idx = 4 + 8*k + j;
            beat[j*32 +: 32] = (idx < len) ? pay[idx] : next_rand();
         end
         send_beat(beat, k == nbeats - 1);
      end
      cq_tvalid = 1'b0;
      cq_tlast  = 1'b0;
      // dword i in slot i mod 8 of word i div 8
      for (int w = 0; w < (len + 7) / 8; w++) begin
         word = '0;
         for (int s = 0; s < 8; s++) begin
            if (8*w + s < len) begin
               word[s*32 +: 32] = pay[8*w + s];
            end
         end
         exp_q.push_back(word);
      end
   endtask

   // single-beat read request with its byte enables on the sideband
   task automatic send_read(input cq_rx_pkg::dw_len_t len, input cq_rx_pkg::ep_addr_t addr,
                            input cq_rx_pkg::rid_t rid, input cq_rx_pkg::tag_t tag,
                            input cq_rx_pkg::tc_t tc, input cq_rx_pkg::attr_t attr,
                            input cq_rx_pkg::be_t be);
      cq_be = be;
      send_beat(make_header(cq_rx_pkg::req_type_t'(`REQ_MEM_RD), len, addr, rid, tag, tc,
                            attr), 1'b1);
      cq_tvalid = 1'b0;
      cq_tlast  = 1'b0;
      cq_be     = '0;
   endtask

   task automatic check_words(input string name);
      int n;
      n = 0;
      while (fifo_q.size() < exp_q.size() && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (fifo_q.size() < exp_q.size()) begin
         $display("timeout: %s is missing fifo words", name);
      end
      repeat (4) @(posedge clk);   // catch stray extra words
      check_eq(256'(fifo_q.size()), 256'(exp_q.size()), {name, " word count"});
      for (int i = 0; i < exp_q.size() && i < fifo_q.size(); i++) begin
         check_eq(fifo_q[i], exp_q[i], $sformatf("%s word %0d", name, i));
      end
      fifo_q.delete();
      exp_q.delete();
      @(negedge clk);
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////
   task automatic test_reset_state();
      check_eq(256'(cq_tready), 256'(1), "ready after reset");
      check_eq(256'(req_compl), 256'(0), "req_compl after reset");
      check_eq(256'(fifo_wr_en), 256'(0), "fifo_wr_en after reset");
      check_eq(256'(rate_valid), 256'(0), "rate_valid after reset");
      check_eq(256'(rate_count), 256'(0), "rate_count after reset");
      end_test("reset state");
   endtask

   task automatic test_short_writes();
      for (int len = 1; len <= 4; len++) begin
         send_write(len);
         check_words($sformatf("short write %0d", len));
      end
      end_test("short writes");
   endtask

   task automatic test_long_writes();
      int lens[4] = '{5, 8, 12, 20};
      for (int i = 0; i < 4; i++) begin
         send_write(lens[i]);
         check_eq(256'(cq_tready), 256'(0), $sformatf("ready in flush, len %0d", lens[i]));
         @(negedge clk);
         check_eq(256'(cq_tready), 256'(1), $sformatf("ready after len %0d", lens[i]));
         check_words($sformatf("long write %0d", lens[i]));
      end
      end_test("long writes");
   endtask

   task automatic test_read();
      logic [31:0] r;
      logic [31:0] a;
      int delay;
      r = next_rand();
      a = next_rand();
      delay = 2 + int'(next_rand() % 32'd20);   // tx side latency
      send_read(cq_rx_pkg::dw_len_t'(1), a[10:0], r[31:16], r[15:8], r[2:0], r[6:4],
                a[23:16]);
      check_eq(256'(req_tc), 256'(r[2:0]), "read tc");
      check_eq(256'(req_attr), 256'(r[6:4]), "read attr");
      check_eq(256'(req_len), 256'(1), "read length");
      check_eq(256'(req_rid), 256'(r[31:16]), "read requester id");
      check_eq(256'(req_tag), 256'(r[15:8]), "read tag");
      check_eq(256'(req_be), 256'(a[23:16]), "read byte enables");
      check_eq(256'(req_addr), 256'(a[10:0]), "read address");
      for (int i = 0; i < delay; i++) begin
         check_eq(256'(req_compl), 256'(1), "req_compl held");
         check_eq(256'(cq_tready), 256'(0), "ready low while pending");
         @(negedge clk);
      end
      compl_done = 1'b1;
      @(negedge clk);
      compl_done = 1'b0;
      check_eq(256'(req_compl), 256'(0), "req_compl after done");
      check_eq(256'(cq_tready), 256'(1), "ready after done");
      check_eq(256'(fifo_q.size()), 256'(0), "no fifo word on read");
      end_test("one-dword read");
   endtask

   task automatic test_ignored();
      cq_rx_pkg::cq_data_t beat;
      compl_cycles = 0;
      send_read(cq_rx_pkg::dw_len_t'(2), 11'h15, 16'h1234, 8'h5a, 3'd1, 3'd2, 8'h0f);
      // unknown type over two beats with the second shaped like a write header
      send_beat(make_header(cq_rx_pkg::req_type_t'(4'hc), cq_rx_pkg::dw_len_t'(10),
                            11'h20, 16'h4321, 8'ha5, 3'd0, 3'd0), 1'b0);
      beat = make_header(cq_rx_pkg::req_type_t'(`REQ_MEM_WR), cq_rx_pkg::dw_len_t'(2),
                         11'h30, 16'h0001, 8'h01, 3'd0, 3'd0);
      beat[255:128] = {4{32'hdeadbeef}};
      send_beat(beat, 1'b1);
      cq_tvalid = 1'b0;
      cq_tlast  = 1'b0;
      repeat (8) @(posedge clk);
      check_eq(256'(fifo_q.size()), 256'(0), "no fifo word when ignored");
      check_eq(256'(compl_cycles), 256'(0), "no req_compl when ignored");
      fifo_q.delete();
      @(negedge clk);
      check_eq(256'(cq_tready), 256'(1), "ready after ignored requests");
      end_test("ignored requests");
   endtask

   task automatic test_rate_meter();
      int n;
      rate_clear = 1'b1;
      @(negedge clk);
      rate_clear = 1'b0;
      send_write(2);
      send_write(3);
      send_write(20);   // 1 + 1 + 3 words
      check_words("rate traffic");
      n = 0;
      while (!rate_valid && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!rate_valid) begin
         errors++;
         $display("timeout: no rate_valid_o pulse after the clear");
      end
      check_eq(256'(rate_count), 256'(5), "words in first window");
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!rate_valid && n < WAIT_LIMIT);
      check_eq(256'(n), 256'(WINDOW), "cycles between rate pulses");
      check_eq(256'(rate_count), 256'(0), "words in idle window");
      end_test("rate meter");
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      cq_tdata        = '0;
      cq_tvalid       = 1'b0;
      cq_tlast        = 1'b0;
      cq_be           = '0;
      compl_done      = 1'b0;
      rate_clear      = 1'b0;
      errors          = 0;
      checks          = 0;
      tests           = 0;
      errors_at_start = 0;
      compl_cycles    = 0;
      rnd_state       = 32'd52;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset_state();
      test_short_writes();
      test_long_writes();
      test_read();
      test_ignored();
      test_rate_meter();
      errors += u_cq_rx_engine.u_sva.assert_fails;   // bound assertion failures
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/cq_rx_pkg.sv
hdl/cq_rx_fsm.sv
hdl/wr_dw_repacker.sv
hdl/rd_req_capture.sv
hdl/rx_rate_meter.sv
hdl/cq_rx_engine.sv
test/cq_rx_engine_sva.sv
test/tb_cq_rx_engine.sv

//--- Makefile
# Verilator flow for the CQ receive engine, run from the project root
TOP := tb_cq_rx_engine

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
